//--- verilog/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// System clock in Hz for the 1 us time tick
`define CSR_SYSTEM_CLK 4_000_000

// mstatus field positions
`define MSTATUS_SIE_BIT 1
`define MSTATUS_MIE_BIT 3
`define MSTATUS_SPIE_BIT 5
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_SPP_BIT 8
`define MSTATUS_MPP_LSB 11
`define MSTATUS_MPRV_BIT 17

`define SATP_MODE_BIT 31

// Delegable bits and supervisor views
`define MEDELEG_MASK 32'h0000_b3ff
`define MIDELEG_MASK 32'h0000_0222
`define SSTATUS_MASK 32'h000c_0122
`define SIE_MASK 32'h0000_0222
`define SIP_MASK 32'h0000_0222

// Interrupt bit numbers in mip and mie
`define MIP_SSIP 1
`define MIP_MSIP 3
`define MIP_STIP 5
`define MIP_MTIP 7
`define MIP_SEIP 9
`define MIP_MEIP 11

`endif

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // Encoded as funct3 of the Zicsr instructions
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW = 3'd1,
    CSR_RS = 3'd2,
    CSR_RC = 3'd3,
    CSR_RWI = 3'd5,
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  // RV32 with A, I, M, S and U
  localparam logic [31:0] MISA_VALUE = 32'h4014_1101;

  localparam logic [11:0] CSR_MISA = 12'h301;
  localparam logic [11:0] CSR_MHARTID = 12'hf14;
  localparam logic [11:0] CSR_CYCLE = 12'hc00;
  localparam logic [11:0] CSR_TIME = 12'hc01;
  localparam logic [11:0] CSR_INSTRET = 12'hc02;
  localparam logic [11:0] CSR_CYCLEH = 12'hc80;
  localparam logic [11:0] CSR_TIMEH = 12'hc81;
  localparam logic [11:0] CSR_INSTRETH = 12'hc82;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MEDELEG = 12'h302;
  localparam logic [11:0] CSR_MIDELEG = 12'h303;
  localparam logic [11:0] CSR_MIE = 12'h304;
  localparam logic [11:0] CSR_MTVEC = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;
  localparam logic [11:0] CSR_MTVAL = 12'h343;
  localparam logic [11:0] CSR_MIP = 12'h344;
  localparam logic [11:0] CSR_MTIMECMP = 12'h7c0;
  localparam logic [11:0] CSR_MTIMECMPH = 12'h7c1;

  localparam logic [11:0] CSR_SSTATUS = 12'h100;
  localparam logic [11:0] CSR_SIE = 12'h104;
  localparam logic [11:0] CSR_STVEC = 12'h105;
  localparam logic [11:0] CSR_SSCRATCH = 12'h140;
  localparam logic [11:0] CSR_SEPC = 12'h141;
  localparam logic [11:0] CSR_SCAUSE = 12'h142;
  localparam logic [11:0] CSR_STVAL = 12'h143;
  localparam logic [11:0] CSR_SIP = 12'h144;
  localparam logic [11:0] CSR_STIMECMP = 12'h14d;
  localparam logic [11:0] CSR_STIMECMPH = 12'h15d;
  localparam logic [11:0] CSR_SATP = 12'h180;

endpackage

`default_nettype wire

//--- verilog/priv_pkg.sv
`default_nettype none

package priv_pkg;

  typedef enum logic [1:0] {
    PRIV_USER = 2'd0,
    PRIV_SUPERVISOR = 2'd1,
    PRIV_MACHINE = 2'd3
  } priv_mode_e;

  // Top bit of mcause marks an interrupt
  localparam logic [31:0] INTERRUPT_FLAG = 32'h8000_0000;

  localparam logic [4:0] IRQ_CAUSE_SSI = 5'd1;
  localparam logic [4:0] IRQ_CAUSE_MSI = 5'd3;
  localparam logic [4:0] IRQ_CAUSE_STI = 5'd5;
  localparam logic [4:0] IRQ_CAUSE_MTI = 5'd7;
  localparam logic [4:0] IRQ_CAUSE_SEI = 5'd9;
  localparam logic [4:0] IRQ_CAUSE_MEI = 5'd11;

endpackage

`default_nettype wire

//--- verilog/perf_counters.sv
`default_nettype none
`include "csr_params.svh"

module perf_counters #(
  parameter int SYSTEM_CLK = `CSR_SYSTEM_CLK
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        incr_inst_retired,
  output logic [63:0] cycle_count,
  output logic [63:0] instret_count,
  output logic [63:0] timer_count
);

  localparam int TICK_DIV = SYSTEM_CLK / 1_000_000;
  localparam logic [17:0] TICK_LAST = 18'(TICK_DIV - 1);

  logic [17:0] tick_cnt;
  logic        tick;

  assign tick = (tick_cnt == TICK_LAST);

  // Microsecond divider
  always_ff @(posedge clk) begin
    if (!resetn || tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 18'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cycle_count <= '0;
      instret_count <= '0;
      timer_count <= '0;
    end else begin
      cycle_count <= cycle_count + 64'd1;
      instret_count <= instret_count + 64'(incr_inst_retired);
      timer_count <= timer_count + 64'(tick);
    end
  end

  tick_spacing_a : assert property (@(posedge clk) disable iff (!resetn)
    (TICK_DIV > 1) && tick |=> !tick)
    else $error("time tick fired on back to back cycles");

endmodule

`default_nettype wire

//--- verilog/irq_ctrl.sv
`default_nettype none
`include "csr_params.svh"

module irq_ctrl (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 ext_irq_m,
  input  logic                 ext_irq_s,
  input  logic [63:0]          timer_count,
  input  logic [63:0]          mtimecmp,
  input  logic [63:0]          stimecmp,
  input  logic [31:0]          mie,
  input  logic [31:0]          mip,
  input  logic [31:0]          mideleg,
  input  logic [31:0]          mstatus,
  input  priv_pkg::priv_mode_e privilege_mode,
  output logic [31:0]          mip_next,
  output logic                 irq_pending,
  output logic [31:0]          irq_cause
);

  import priv_pkg::*;

  logic [31:0] enabled;
  logic [31:0] taken;
  logic        m_global;
  logic        s_global;

  // Software bits stay and hardware sources overwrite theirs
  always_comb begin
    mip_next = mip;
    mip_next[`MIP_MTIP] = (timer_count >= mtimecmp);
    mip_next[`MIP_STIP] = (timer_count >= stimecmp);
    mip_next[`MIP_MEIP] = ext_irq_m;
    mip_next[`MIP_SEIP] = ext_irq_s;
  end

  assign enabled = mie & mip;
  assign m_global = (privilege_mode != PRIV_MACHINE) || mstatus[`MSTATUS_MIE_BIT];
  assign s_global = (privilege_mode == PRIV_USER) ||
                    (privilege_mode == PRIV_SUPERVISOR && mstatus[`MSTATUS_SIE_BIT]);
  assign taken = (enabled & ~mideleg & {32{m_global}}) | (enabled & mideleg & {32{s_global}});

  // MEI > MSI > MTI > SEI > SSI > STI
  always_comb begin
    irq_pending = 1'b1;
    if (taken[`MIP_MEIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_MEI);
    end else if (taken[`MIP_MSIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_MSI);
    end else if (taken[`MIP_MTIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_MTI);
    end else if (taken[`MIP_SEIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_SEI);
    end else if (taken[`MIP_SSIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_SSI);
    end else if (taken[`MIP_STIP]) begin
      irq_cause = INTERRUPT_FLAG | 32'(IRQ_CAUSE_STI);
    end else begin
      irq_pending = 1'b0;
      irq_cause = '0;
    end
  end

  // Cause code must name an enabled and pending bit of mie and mip
  cause_flag_a : assert property (@(posedge clk) disable iff (!resetn)
    irq_pending |-> irq_cause[31] && mie[irq_cause[4:0]] && mip[irq_cause[4:0]])
    else $error("pending interrupt cause lacks the flag or an enabled pending source");

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`default_nettype none
`include "csr_params.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [11:0]          csr_addr,
  input  csr_pkg::csr_op_e     csr_op,
  input  logic                 we,
  input  logic [31:0]          rs1_data,
  input  logic [4:0]           uimm,
  input  logic                 exception_event,
  input  logic                 mret,
  input  logic                 sret,
  input  logic [31:0]          cause,
  input  logic [31:0]          pc,
  input  logic [31:0]          badaddr,
  input  logic [63:0]          cycle_count,
  input  logic [63:0]          instret_count,
  input  logic [63:0]          timer_count,
  input  logic [31:0]          mip_next,
  output logic [31:0]          rdata,
  output logic                 csr_access_fault,
  output logic [31:0]          exception_next_pc,
  output logic                 exception_select,
  output priv_pkg::priv_mode_e privilege_mode,
  output logic [31:0]          mstatus,
  output logic [31:0]          satp,
  output logic                 tlb_flush,
  output logic [31:0]          mie,
  output logic [31:0]          mip,
  output logic [31:0]          mideleg,
  output logic [63:0]          mtimecmp,
  output logic [63:0]          stimecmp
);

  import csr_pkg::*;
  import priv_pkg::*;

  logic [31:0] mtvec, mepc, mcause, mtval, mscratch, medeleg;
  logic [31:0] stvec, sepc, scause, stval, sscratch;
  logic        csr_unknown;
  logic        write_valid;
  logic [31:0] operand;
  logic [31:0] wdata;
  logic [31:0] deleg_bits;
  logic        trap_to_s;
  logic [1:0]  mpp;
  priv_mode_e  mpp_mode;

  function automatic logic [31:0] trap_target(input logic [31:0] vec, input logic [31:0] c);
    logic [31:0] base;
    base = {vec[31:2], 2'b00};
    return (vec[1:0] == 2'b01) ? (base | (c << 2)) : base;
  endfunction

  always_comb begin
    csr_unknown = 1'b0;
    rdata = '0;
    case (csr_addr)
      CSR_MISA: rdata = MISA_VALUE;
      CSR_MHARTID: rdata = 32'h0;
      CSR_CYCLE: rdata = cycle_count[31:0];
      CSR_CYCLEH: rdata = cycle_count[63:32];
      CSR_TIME: rdata = timer_count[31:0];
      CSR_TIMEH: rdata = timer_count[63:32];
      CSR_INSTRET: rdata = instret_count[31:0];
      CSR_INSTRETH: rdata = instret_count[63:32];
      CSR_MSTATUS: rdata = mstatus;
      CSR_MEDELEG: rdata = medeleg;
      CSR_MIDELEG: rdata = mideleg;
      CSR_MIE: rdata = mie;
      CSR_MIP: rdata = mip;
      CSR_MTVEC: rdata = mtvec;
      CSR_MSCRATCH: rdata = mscratch;
      CSR_MEPC: rdata = mepc;
      CSR_MCAUSE: rdata = mcause;
      CSR_MTVAL: rdata = mtval;
      CSR_MTIMECMP: rdata = mtimecmp[31:0];
      CSR_MTIMECMPH: rdata = mtimecmp[63:32];
      CSR_SSTATUS: rdata = mstatus & `SSTATUS_MASK;
      CSR_SIE: rdata = mie & `SIE_MASK;
      CSR_SIP: rdata = mip & `SIP_MASK;
      CSR_STVEC: rdata = stvec;
      CSR_SSCRATCH: rdata = sscratch;
      CSR_SEPC: rdata = sepc;
      CSR_SCAUSE: rdata = scause;
      CSR_STVAL: rdata = stval;
      CSR_STIMECMP: rdata = stimecmp[31:0];
      CSR_STIMECMPH: rdata = stimecmp[63:32];
      CSR_SATP: rdata = satp;
      default: csr_unknown = 1'b1;
    endcase
  end

  // Privilege field, read-only space, unknown address
  assign csr_access_fault = (csr_addr[9:8] > 2'(privilege_mode)) ||
                            (we && csr_addr[11:10] == 2'b11) || csr_unknown;
  assign write_valid = we && !csr_access_fault && (csr_op != CSR_NONE);

  assign operand = (csr_op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {27'b0, uimm} : rs1_data;

  always_comb begin
    case (csr_op)
      CSR_RS, CSR_RSI: wdata = rdata | operand;
      CSR_RC, CSR_RCI: wdata = rdata & ~operand;
      default: wdata = operand;
    endcase
  end

  assign tlb_flush = write_valid && (csr_addr == CSR_SATP) &&
                     (wdata[`SATP_MODE_BIT] != satp[`SATP_MODE_BIT]);

  assign deleg_bits = cause[31] ? mideleg : medeleg;
  assign trap_to_s = (privilege_mode != PRIV_MACHINE) && deleg_bits[cause[4:0]];

  // Reserved MPP encoding returns to user
  assign mpp = mstatus[`MSTATUS_MPP_LSB +: 2];
  assign mpp_mode = (mpp == 2'b10) ? PRIV_USER : priv_mode_e'(mpp);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      privilege_mode <= PRIV_MACHINE;
      exception_select <= 1'b0;
      exception_next_pc <= '0;
      {mstatus, mie, mip, mideleg, medeleg, mtvec, mepc, mcause} <= '0;
      {mtval, mscratch, stvec, sepc, scause, stval, sscratch, satp} <= '0;
      mtimecmp <= '0;
      stimecmp <= '0;
    end else begin
      exception_select <= exception_event || mret || sret;
      mip <= mip_next;
      if (exception_event && trap_to_s) begin
        sepc <= pc;
        scause <= cause;
        stval <= badaddr;
        mstatus[`MSTATUS_SPIE_BIT] <= mstatus[`MSTATUS_SIE_BIT];
        mstatus[`MSTATUS_SIE_BIT] <= 1'b0;
        mstatus[`MSTATUS_SPP_BIT] <= (privilege_mode == PRIV_SUPERVISOR);
        privilege_mode <= PRIV_SUPERVISOR;
        exception_next_pc <= trap_target(stvec, cause);
      end else if (exception_event) begin
        mepc <= pc;
        mcause <= cause;
        mtval <= badaddr;
        mstatus[`MSTATUS_MPIE_BIT] <= mstatus[`MSTATUS_MIE_BIT];
        mstatus[`MSTATUS_MIE_BIT] <= 1'b0;
        mstatus[`MSTATUS_MPP_LSB +: 2] <= privilege_mode;
        privilege_mode <= PRIV_MACHINE;
        exception_next_pc <= trap_target(mtvec, cause);
      end else if (mret) begin
        mstatus[`MSTATUS_MIE_BIT] <= mstatus[`MSTATUS_MPIE_BIT];
        mstatus[`MSTATUS_MPIE_BIT] <= 1'b1;
        mstatus[`MSTATUS_MPP_LSB +: 2] <= PRIV_USER;
        if (mpp_mode != PRIV_MACHINE) begin
          mstatus[`MSTATUS_MPRV_BIT] <= 1'b0;
        end
        privilege_mode <= mpp_mode;
        exception_next_pc <= mepc;
      end else if (sret) begin
        // Always leaves for a mode below machine
        mstatus[`MSTATUS_SIE_BIT] <= mstatus[`MSTATUS_SPIE_BIT];
        mstatus[`MSTATUS_SPIE_BIT] <= 1'b1;
        mstatus[`MSTATUS_SPP_BIT] <= 1'b0;
        mstatus[`MSTATUS_MPRV_BIT] <= 1'b0;
        privilege_mode <= mstatus[`MSTATUS_SPP_BIT] ? PRIV_SUPERVISOR : PRIV_USER;
        exception_next_pc <= sepc;
      end else if (write_valid) begin
        case (csr_addr)
          CSR_MSTATUS: mstatus <= wdata;
          CSR_MEDELEG: medeleg <= wdata & `MEDELEG_MASK;
          CSR_MIDELEG: mideleg <= wdata & `MIDELEG_MASK;
          CSR_MIE: mie <= wdata;
          CSR_MIP: mip <= wdata;
          CSR_MTVEC: mtvec <= wdata;
          CSR_MSCRATCH: mscratch <= wdata;
          CSR_MEPC: mepc <= wdata;
          CSR_MCAUSE: mcause <= wdata;
          CSR_MTVAL: mtval <= wdata;
          CSR_MTIMECMP: mtimecmp[31:0] <= wdata;
          CSR_MTIMECMPH: mtimecmp[63:32] <= wdata;
          CSR_SSTATUS: mstatus <= (mstatus & ~`SSTATUS_MASK) | (wdata & `SSTATUS_MASK);
          CSR_SIE: mie <= (mie & ~`SIE_MASK) | (wdata & `SIE_MASK);
          CSR_SIP: mip <= (mip & ~`SIP_MASK) | (wdata & `SIP_MASK);
          CSR_STVEC: stvec <= wdata;
          CSR_SSCRATCH: sscratch <= wdata;
          CSR_SEPC: sepc <= wdata;
          CSR_SCAUSE: scause <= wdata;
          CSR_STVAL: stval <= wdata;
          CSR_STIMECMP: stimecmp[31:0] <= wdata;
          CSR_STIMECMPH: stimecmp[63:32] <= wdata;
          CSR_SATP: satp <= wdata;
          default: ;
        endcase
      end
    end
  end

  fault_no_write_a : assert property (@(posedge clk) disable iff (!resetn)
    we && csr_access_fault && !exception_event && !mret && !sret
    |=> $stable({mstatus, mie, mideleg, medeleg, mtvec, mepc, mcause, mtval, mscratch}) &&
        $stable({stvec, sepc, scause, stval, sscratch, satp, mtimecmp, stimecmp}))
    else $error("faulting CSR write changed a register");

  select_single_a : assert property (@(posedge clk) disable iff (!resetn)
    exception_select |=> !exception_select)
    else $error("exception_select high on two cycles in a row");

endmodule

`default_nettype wire

//--- verilog/csr_subsystem.sv
`default_nettype none

module csr_subsystem (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [11:0]          csr_addr,
  input  csr_pkg::csr_op_e     csr_op,
  input  logic                 we,
  input  logic [31:0]          rs1_data,
  input  logic [4:0]           uimm,
  input  logic                 exception_event,
  input  logic [31:0]          cause,
  input  logic [31:0]          pc,
  input  logic [31:0]          badaddr,
  input  logic                 mret,
  input  logic                 sret,
  input  logic                 incr_inst_retired,
  input  logic                 ext_irq_m,
  input  logic                 ext_irq_s,
  output logic [31:0]          rdata,
  output logic                 csr_access_fault,
  output logic [31:0]          exception_next_pc,
  output logic                 exception_select,
  output priv_pkg::priv_mode_e privilege_mode,
  output logic [31:0]          mstatus,
  output logic [31:0]          satp,
  output logic                 tlb_flush,
  output logic                 irq_pending,
  output logic [31:0]          irq_cause
);

  logic [63:0] cycle_count;
  logic [63:0] instret_count;
  logic [63:0] timer_count;
  logic [31:0] mie;
  logic [31:0] mip;
  logic [31:0] mideleg;
  logic [31:0] mip_next;
  logic [63:0] mtimecmp;
  logic [63:0] stimecmp;

  perf_counters counters_i (
    .clk(clk),
    .resetn(resetn),
    .incr_inst_retired(incr_inst_retired),
    .cycle_count(cycle_count),
    .instret_count(instret_count),
    .timer_count(timer_count)
  );

  irq_ctrl irq_ctrl_i (
    .clk(clk),
    .resetn(resetn),
    .ext_irq_m(ext_irq_m),
    .ext_irq_s(ext_irq_s),
    .timer_count(timer_count),
    .mtimecmp(mtimecmp),
    .stimecmp(stimecmp),
    .mie(mie),
    .mip(mip),
    .mideleg(mideleg),
    .mstatus(mstatus),
    .privilege_mode(privilege_mode),
    .mip_next(mip_next),
    .irq_pending(irq_pending),
    .irq_cause(irq_cause)
  );

  csr_unit csr_unit_i (
    .clk(clk),
    .resetn(resetn),
    .csr_addr(csr_addr),
    .csr_op(csr_op),
    .we(we),
    .rs1_data(rs1_data),
    .uimm(uimm),
    .exception_event(exception_event),
    .mret(mret),
    .sret(sret),
    .cause(cause),
    .pc(pc),
    .badaddr(badaddr),
    .cycle_count(cycle_count),
    .instret_count(instret_count),
    .timer_count(timer_count),
    .mip_next(mip_next),
    .rdata(rdata),
    .csr_access_fault(csr_access_fault),
    .exception_next_pc(exception_next_pc),
    .exception_select(exception_select),
    .privilege_mode(privilege_mode),
    .mstatus(mstatus),
    .satp(satp),
    .tlb_flush(tlb_flush),
    .mie(mie),
    .mip(mip),
    .mideleg(mideleg),
    .mtimecmp(mtimecmp),
    .stimecmp(stimecmp)
  );

endmodule

`default_nettype wire

//--- testbench/tb_csr_subsystem.sv
`default_nettype none
`include "csr_params.svh"

module tb_csr_subsystem;

  timeunit 1ns;
  timeprecision 100ps;

  import csr_pkg::*;
  import priv_pkg::*;

  localparam logic [63:0] TICK_DIV = 64'(`CSR_SYSTEM_CLK / 1_000_000);
  localparam int CYCLE_LIMIT = 2000;

  logic        clk;
  logic        resetn;
  logic [11:0] csr_addr;
  csr_op_e     csr_op;
  logic        we;
  logic [31:0] rs1_data;
  logic [4:0]  uimm;
  logic        exception_event;
  logic [31:0] cause;
  logic [31:0] pc;
  logic [31:0] badaddr;
  logic        mret;
  logic        sret;
  logic        incr_inst_retired;
  logic        ext_irq_m;
  logic        ext_irq_s;
  logic [31:0] rdata;
  logic        csr_access_fault;
  logic [31:0] exception_next_pc;
  logic        exception_select;
  priv_mode_e  privilege_mode;
  logic [31:0] mstatus;
  logic [31:0] satp;
  logic        tlb_flush;
  logic        irq_pending;
  logic [31:0] irq_cause;

  // Shadow model, indexed by CSR address
  logic [31:0] model [4096];
  priv_mode_e  model_priv;
  logic [63:0] cycles_seen;
  logic [63:0] retire_total;
  int          cycle_total;
  int          value_errors;
  int          flag_errors;

  // What the next edge must see
  logic        check_rdata;
  logic [31:0] exp_rdata;
  logic [31:0] rdata_mask;
  logic        check_fault;
  logic        exp_fault;
  logic        check_select;
  logic        exp_select;
  logic [31:0] exp_next_pc;
  logic        exp_flush;
  logic        check_irq;
  logic        exp_irq_pending;
  logic [31:0] exp_irq_cause;

  csr_subsystem dut_i (
    .clk(clk),
    .resetn(resetn),
    .csr_addr(csr_addr),
    .csr_op(csr_op),
    .we(we),
    .rs1_data(rs1_data),
    .uimm(uimm),
    .exception_event(exception_event),
    .cause(cause),
    .pc(pc),
    .badaddr(badaddr),
    .mret(mret),
    .sret(sret),
    .incr_inst_retired(incr_inst_retired),
    .ext_irq_m(ext_irq_m),
    .ext_irq_s(ext_irq_s),
    .rdata(rdata),
    .csr_access_fault(csr_access_fault),
    .exception_next_pc(exception_next_pc),
    .exception_select(exception_select),
    .privilege_mode(privilege_mode),
    .mstatus(mstatus),
    .satp(satp),
    .tlb_flush(tlb_flush),
    .irq_pending(irq_pending),
    .irq_cause(irq_cause)
  );

  always #50 clk = ~clk;

  // Reference cycle count since reset
  always @(posedge clk) begin
    if (!resetn) begin
      cycles_seen <= '0;
    end else begin
      cycles_seen <= cycles_seen + 64'd1;
    end
  end

  always @(posedge clk) begin
    cycle_total++;
    if (cycle_total >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  rdata_a : assert property (@(posedge clk) disable iff (!resetn)
    check_rdata |-> (rdata & rdata_mask) == exp_rdata)
    else begin
      value_errors++;
      $display("MISMATCH at %0t: csr %h read %h, expected %h under mask %h", $time,
               $sampled(csr_addr), $sampled(rdata), exp_rdata, rdata_mask);
    end

  state_a : assert property (@(posedge clk) disable iff (!resetn)
    privilege_mode == model_priv && mstatus == model[CSR_MSTATUS] && satp == model[CSR_SATP])
    else begin
      value_errors++;
      $display("MISMATCH at %0t: mode %0d mstatus %h satp %h, expected %0d %h %h", $time,
               $sampled(privilege_mode), $sampled(mstatus), $sampled(satp),
               model_priv, model[CSR_MSTATUS], model[CSR_SATP]);
    end

  fault_a : assert property (@(posedge clk) disable iff (!resetn)
    check_fault |-> csr_access_fault == exp_fault)
    else begin
      flag_errors++;
      $display("MISMATCH at %0t: csr_access_fault %b for csr %h, expected %b", $time,
               $sampled(csr_access_fault), $sampled(csr_addr), exp_fault);
    end

  redirect_a : assert property (@(posedge clk) disable iff (!resetn)
    check_select |-> exception_select == exp_select &&
                     (!exp_select || exception_next_pc == exp_next_pc))
    else begin
      flag_errors++;
      $display("MISMATCH at %0t: exception_select %b next pc %h, expected %b %h", $time,
               $sampled(exception_select), $sampled(exception_next_pc),
               exp_select, exp_next_pc);
    end

  flush_a : assert property (@(posedge clk) disable iff (!resetn)
    tlb_flush == exp_flush)
    else begin
      flag_errors++;
      $display("MISMATCH at %0t: tlb_flush %b, expected %b", $time,
               $sampled(tlb_flush), exp_flush);
    end

  irq_a : assert property (@(posedge clk) disable iff (!resetn)
    check_irq |-> irq_pending == exp_irq_pending &&
                  (!exp_irq_pending || irq_cause == exp_irq_cause))
    else begin
      flag_errors++;
      $display("MISMATCH at %0t: irq_pending %b cause %h, expected %b %h", $time,
               $sampled(irq_pending), $sampled(irq_cause), exp_irq_pending, exp_irq_cause);
    end

  function automatic logic [31:0] trap_vector_pc(input logic [31:0] vec, input logic [31:0] c);
    logic [31:0] base;
    base = {vec[31:2], 2'b00};
    if (vec[1:0] == 2'b01) begin
      return base | (c << 2);
    end
    return base;
  endfunction

  // Advance to the next drive point with all strobes idle
  task automatic next_cycle();
    @(posedge clk);
    #5;
    we = 1'b0;
    csr_op = CSR_NONE;
    exception_event = 1'b0;
    mret = 1'b0;
    sret = 1'b0;
    incr_inst_retired = 1'b0;
    check_rdata = 1'b0;
    check_fault = 1'b0;
    check_select = 1'b0;
    check_irq = 1'b0;
    exp_flush = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] addr, input csr_op_e op, input logic [31:0] data,
                           input logic [4:0] imm, input logic expect_fault);
    logic [31:0] operand;
    logic [31:0] next_value;
    operand = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {27'b0, imm} : data;
    case (op)
      CSR_RS, CSR_RSI: next_value = model[addr] | operand;
      CSR_RC, CSR_RCI: next_value = model[addr] & ~operand;
      default: next_value = operand;
    endcase
    if (addr == CSR_MEDELEG) begin
      next_value = next_value & `MEDELEG_MASK;
    end else if (addr == CSR_MIDELEG) begin
      next_value = next_value & `MIDELEG_MASK;
    end
    csr_addr = addr;
    csr_op = op;
    we = 1'b1;
    rs1_data = data;
    uimm = imm;
    check_fault = 1'b1;
    exp_fault = expect_fault;
    check_rdata = !expect_fault;
    exp_rdata = model[addr];
    rdata_mask = '1;
    exp_flush = !expect_fault && addr == CSR_SATP &&
                next_value[`SATP_MODE_BIT] != model[CSR_SATP][`SATP_MODE_BIT];
    next_cycle();
    if (!expect_fault) begin
      model[addr] = next_value;
    end
  endtask

  task automatic csr_read(input logic [11:0] addr, input logic [31:0] expected,
                          input logic [31:0] mask, input logic expect_fault);
    csr_addr = addr;
    csr_op = CSR_NONE;
    we = 1'b0;
    check_fault = 1'b1;
    exp_fault = expect_fault;
    check_rdata = !expect_fault;
    exp_rdata = expected & mask;
    rdata_mask = mask;
    next_cycle();
  endtask

  task automatic check_model(input logic [11:0] addr);
    csr_read(addr, model[addr], '1, 1'b0);
  endtask

  task automatic exercise_ops(input logic [11:0] addr);
    csr_op_e op_seq [6];
    op_seq = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    foreach (op_seq[i]) begin
      csr_write(addr, op_seq[i], $urandom, 5'($urandom), 1'b0);
      check_model(addr);
    end
  endtask

  // Select low in the event cycle, high one cycle later, then low again
  task automatic check_redirect(input logic [31:0] target);
    check_select = 1'b1;
    exp_select = 1'b1;
    exp_next_pc = target;
    next_cycle();
    check_select = 1'b1;
    exp_select = 1'b0;
    next_cycle();
  endtask

  task automatic take_exception(input logic [31:0] c, input logic [31:0] epc,
                                input logic [31:0] bad);
    logic [31:0] deleg;
    logic        to_s;
    logic [31:0] st;
    logic [31:0] target;
    priv_mode_e  priv_next;
    st = model[CSR_MSTATUS];
    deleg = c[31] ? model[CSR_MIDELEG] : model[CSR_MEDELEG];
    to_s = model_priv != PRIV_MACHINE && deleg[c[4:0]];
    if (to_s) begin
      target = trap_vector_pc(model[CSR_STVEC], c);
      st[`MSTATUS_SPIE_BIT] = st[`MSTATUS_SIE_BIT];
      st[`MSTATUS_SIE_BIT] = 1'b0;
      st[`MSTATUS_SPP_BIT] = (model_priv == PRIV_SUPERVISOR);
      priv_next = PRIV_SUPERVISOR;
    end else begin
      target = trap_vector_pc(model[CSR_MTVEC], c);
      st[`MSTATUS_MPIE_BIT] = st[`MSTATUS_MIE_BIT];
      st[`MSTATUS_MIE_BIT] = 1'b0;
      st[`MSTATUS_MPP_LSB +: 2] = model_priv;
      priv_next = PRIV_MACHINE;
    end
    exception_event = 1'b1;
    cause = c;
    pc = epc;
    badaddr = bad;
    check_select = 1'b1;
    exp_select = 1'b0;
    next_cycle();
    if (to_s) begin
      model[CSR_SEPC] = epc;
      model[CSR_SCAUSE] = c;
      model[CSR_STVAL] = bad;
    end else begin
      model[CSR_MEPC] = epc;
      model[CSR_MCAUSE] = c;
      model[CSR_MTVAL] = bad;
    end
    model[CSR_MSTATUS] = st;
    model_priv = priv_next;
    check_redirect(target);
  endtask

  task automatic machine_return();
    logic [31:0] st;
    priv_mode_e  priv_next;
    st = model[CSR_MSTATUS];
    priv_next = priv_mode_e'(st[`MSTATUS_MPP_LSB +: 2]);
    st[`MSTATUS_MIE_BIT] = st[`MSTATUS_MPIE_BIT];
    st[`MSTATUS_MPIE_BIT] = 1'b1;
    st[`MSTATUS_MPP_LSB +: 2] = 2'b00;
    if (priv_next != PRIV_MACHINE) begin
      st[`MSTATUS_MPRV_BIT] = 1'b0;
    end
    mret = 1'b1;
    check_select = 1'b1;
    exp_select = 1'b0;
    next_cycle();
    model[CSR_MSTATUS] = st;
    model_priv = priv_next;
    check_redirect(model[CSR_MEPC]);
  endtask

  task automatic supervisor_return();
    logic [31:0] st;
    priv_mode_e  priv_next;
    st = model[CSR_MSTATUS];
    priv_next = st[`MSTATUS_SPP_BIT] ? PRIV_SUPERVISOR : PRIV_USER;
    st[`MSTATUS_SIE_BIT] = st[`MSTATUS_SPIE_BIT];
    st[`MSTATUS_SPIE_BIT] = 1'b1;
    st[`MSTATUS_SPP_BIT] = 1'b0;
    st[`MSTATUS_MPRV_BIT] = 1'b0;
    sret = 1'b1;
    check_select = 1'b1;
    exp_select = 1'b0;
    next_cycle();
    model[CSR_MSTATUS] = st;
    model_priv = priv_next;
    check_redirect(model[CSR_SEPC]);
  endtask

  task automatic pulse_retire();
    incr_inst_retired = 1'b1;
    retire_total = retire_total + 64'd1;
    next_cycle();
  endtask

  task automatic expect_irq(input logic pending, input logic [31:0] cause_value);
    check_irq = 1'b1;
    exp_irq_pending = pending;
    exp_irq_cause = cause_value;
    next_cycle();
  endtask

  initial begin
    logic [31:0] base;
    int          pulses;
    void'($urandom(32'h5a6f29bb));
    clk = 1'b0;
    resetn = 1'b0;
    csr_addr = '0;
    csr_op = CSR_NONE;
    we = 1'b0;
    rs1_data = '0;
    uimm = '0;
    exception_event = 1'b0;
    cause = '0;
    pc = '0;
    badaddr = '0;
    mret = 1'b0;
    sret = 1'b0;
    incr_inst_retired = 1'b0;
    ext_irq_m = 1'b0;
    ext_irq_s = 1'b0;
    check_rdata = 1'b0;
    exp_rdata = '0;
    rdata_mask = '1;
    check_fault = 1'b0;
    exp_fault = 1'b0;
    check_select = 1'b0;
    exp_select = 1'b0;
    exp_next_pc = '0;
    exp_flush = 1'b0;
    check_irq = 1'b0;
    exp_irq_pending = 1'b0;
    exp_irq_cause = '0;
    foreach (model[i]) model[i] = '0;
    model_priv = PRIV_MACHINE;
    retire_total = '0;
    cycle_total = 0;
    value_errors = 0;
    flag_errors = 0;
    repeat (16) @(posedge clk);
    #5;
    resetn = 1'b1;

    exercise_ops(CSR_MSCRATCH);
    exercise_ops(CSR_MTVEC);

    // Read-only counter and unknown address
    csr_write(CSR_CYCLE, CSR_RW, $urandom, 5'd0, 1'b1);
    csr_read(CSR_CYCLE, cycles_seen[31:0], '1, 1'b0);
    csr_read(12'h3ff, '0, '0, 1'b1);

    // Machine trap in direct and then vectored mode
    base = $urandom & 32'hffff_fffc;
    csr_write(CSR_MTVEC, CSR_RW, base, 5'd0, 1'b0);
    take_exception(32'd2, $urandom, $urandom);
    check_model(CSR_MEPC);
    check_model(CSR_MCAUSE);
    check_model(CSR_MTVAL);
    csr_read(CSR_MSTATUS, 32'h0000_1800, 32'h0000_1800, 1'b0);
    machine_return();
    csr_read(CSR_MSTATUS, 32'h0, 32'h0000_1800, 1'b0);
    csr_write(CSR_MTVEC, CSR_RW, base | 32'h1, 5'd0, 1'b0);
    take_exception(32'd5, $urandom, $urandom);
    check_model(CSR_MCAUSE);
    machine_return();

    // Down to supervisor with ecall from U delegated
    csr_write(CSR_STVEC, CSR_RW, $urandom & 32'hffff_fffc, 5'd0, 1'b0);
    csr_write(CSR_MEDELEG, CSR_RW, 32'h0000_0100, 5'd0, 1'b0);
    csr_write(CSR_MSTATUS, CSR_RW, 32'h0000_0800, 5'd0, 1'b0);
    machine_return();
    csr_write(CSR_SSCRATCH, CSR_RW, $urandom, 5'd0, 1'b0);
    check_model(CSR_SSCRATCH);
    csr_read(CSR_MSCRATCH, '0, '0, 1'b1);
    take_exception(32'd8, $urandom, $urandom);
    check_model(CSR_SEPC);
    check_model(CSR_SCAUSE);
    supervisor_return();
    take_exception(32'd2, $urandom, $urandom);
    check_model(CSR_MEPC);
    csr_read(CSR_MSTATUS, 32'h0000_0800, 32'h0000_1800, 1'b0);

    // Counters
    csr_read(CSR_CYCLE, cycles_seen[31:0], '1, 1'b0);
    csr_read(CSR_CYCLEH, cycles_seen[63:32], '1, 1'b0);
    csr_read(CSR_TIME, 32'(cycles_seen / TICK_DIV), '1, 1'b0);
    pulses = 3 + int'($urandom % 6);
    repeat (pulses) pulse_retire();
    csr_read(CSR_INSTRET, retire_total[31:0], '1, 1'b0);
    csr_read(CSR_CYCLE, cycles_seen[31:0], '1, 1'b0);
    csr_read(CSR_TIME, 32'(cycles_seen / TICK_DIV), '1, 1'b0);

    // Timer interrupt and then the higher priority external one
    expect_irq(1'b0, '0);
    csr_write(CSR_MTIMECMPH, CSR_RW, 32'h0, 5'd0, 1'b0);
    csr_write(CSR_MTIMECMP, CSR_RW, 32'h1, 5'd0, 1'b0);
    csr_write(CSR_MIE, CSR_RW, 32'h1 << `MIP_MTIP, 5'd0, 1'b0);
    csr_write(CSR_MSTATUS, CSR_RS, 32'h1 << `MSTATUS_MIE_BIT, 5'd0, 1'b0);
    expect_irq(1'b1, INTERRUPT_FLAG | 32'(IRQ_CAUSE_MTI));
    csr_read(CSR_MIP, 32'h1 << `MIP_MTIP, 32'h1 << `MIP_MTIP, 1'b0);
    ext_irq_m = 1'b1;
    csr_write(CSR_MIE, CSR_RS, 32'h1 << `MIP_MEIP, 5'd0, 1'b0);
    expect_irq(1'b1, INTERRUPT_FLAG | 32'(IRQ_CAUSE_MEI));
    ext_irq_m = 1'b0;

    // satp mode flips flush the TLB
    csr_write(CSR_SATP, CSR_RW, $urandom | 32'h8000_0000, 5'd0, 1'b0);
    csr_write(CSR_SATP, CSR_RS, $urandom, 5'd0, 1'b0);
    csr_write(CSR_SATP, CSR_RC, 32'h8000_0000, 5'd0, 1'b0);
    check_model(CSR_SATP);

    next_cycle();
    next_cycle();
    $display("Checks done: %0d value mismatches, %0d flag mismatches",
             value_errors, flag_errors);
    if (value_errors == 0 && flag_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- csr_subsystem.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/priv_pkg.sv
verilog/perf_counters.sv
verilog/irq_ctrl.sv
verilog/csr_unit.sv
verilog/csr_subsystem.sv
testbench/tb_csr_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP       = tb_csr_subsystem
FILELIST  = csr_subsystem.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
